// File: hdl/gpio_pkg.sv
/* Shared package: Wishbone widths, register addresses,
   debounce timing constants and the bus controller state type */
package gpio_pkg;

  // ------------------------------------------------------------
  // Wishbone bus
  // ------------------------------------------------------------
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  // One select bit per data byte
  localparam int WB_SW = WB_DW / 8;

  // ------------------------------------------------------------
  // GPIO block
  // ------------------------------------------------------------
  localparam int GPIO_W = 16;

  // Base address holds the output register for writes and the switches for reads
  localparam logic [WB_AW-1:0] GPIO_OUT_ADDR = 32'h0000_0400;
  // Readback of the output register sits one word above the base
  localparam logic [WB_AW-1:0] GPIO_RB_ADDR  = GPIO_OUT_ADDR + 32'h0000_0004;

  // ------------------------------------------------------------
  // Switch debounce
  // ------------------------------------------------------------
  // Clock cycles between two sampling ticks
  localparam int TICK_DIV     = 16;
  localparam int TICK_CW      = $clog2(TICK_DIV);
  // Equal consecutive samples needed before a switch value is taken
  localparam int DEBOUNCE_CNT = 3;
  localparam int DB_CW        = $clog2(DEBOUNCE_CNT + 1);

  // ------------------------------------------------------------
  // Bus controller state
  // ------------------------------------------------------------
  // IDLE accepts a request, ACK is the single acknowledge cycle
  typedef enum logic [0:0] {
    IDLE = 1'b0,
    ACK  = 1'b1
  } bus_state_t;

endpackage

// File: hdl/wb_bus_fsm.sv
/* Wishbone slave controller: IDLE/ACK state machine,
   accept pulses for reads and writes, and the registered acknowledge */
`timescale 1ns/1ps

module wb_bus_fsm
  import gpio_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       we_i,
  output logic       wr_acc_o,
  output logic       rd_acc_o,
  output logic       ack_o,
  output bus_state_t state_o
);

  bus_state_t state_q;
  bus_state_t state_d;
  logic       req;

  // A request exists only while both cycle and strobe are raised
  assign req = cyc_i & stb_i;

  // ------------------------------------------------------------
  // Accept pulses
  // ------------------------------------------------------------
  // Requests are taken only in IDLE, so a request held through ACK
  // is deferred until the controller has returned to IDLE
  assign wr_acc_o = (state_q == IDLE) & req & we_i;
  assign rd_acc_o = (state_q == IDLE) & req & ~we_i;

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req) begin
          state_d = ACK;
        end
      end
      // ACK lasts exactly one cycle, whatever the bus inputs do
      ACK: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // State and acknowledge registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ack_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      // The acknowledge follows the accept edge by one cycle
      ack_o   <= wr_acc_o | rd_acc_o;
    end
  end

  assign state_o = state_q;

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  // Every transfer is single-beat, so acknowledges never run together
  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_o |=> !ack_o);

endmodule

// File: hdl/sample_timer.sv
/* Sampling timer: wrapping divider counter that emits
   a one-cycle tick every TICK_DIV clock cycles */
`timescale 1ns/1ps

module sample_timer
  import gpio_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  output logic tick_o
);

  logic [TICK_CW-1:0] cnt_q;

  // The tick marks the last count before the wrap
  assign tick_o = (cnt_q == TICK_CW'(TICK_DIV - 1));

  // Count runs from zero after reset release and restarts on each tick
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (tick_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  // Ticks are spaced by the full divider period
  a_tick_spacing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tick_o |=> (!tick_o) [*(TICK_DIV - 1)]);

endmodule

// File: hdl/switch_debounce.sv
/* Switch input conditioning: two-flop synchroniser and
   a debounce filter that samples on the timer tick */
`timescale 1ns/1ps

module switch_debounce
  import gpio_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [GPIO_W-1:0] sw_i,
  input  logic              tick_i,
  output logic [GPIO_W-1:0] sw_stable_o
);

  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] sample_q;
  logic [DB_CW-1:0]  cnt_q;
  logic              same;

  // Switches are asynchronous to the bus clock
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= sw_i;
      sync2_q <= sync1_q;
    end
  end

  // Current synchronised value against the one taken on the last tick
  assign same = (sync2_q == sample_q);

  // ------------------------------------------------------------
  // Debounce filter
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sample_q    <= '0;
      cnt_q       <= '0;
      sw_stable_o <= '0;
    end else if (tick_i) begin
      sample_q <= sync2_q;
      if (!same) begin
        // Any bounce restarts the run of equal samples
        cnt_q <= '0;
      end else if (cnt_q != DB_CW'(DEBOUNCE_CNT)) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // The run reaches its length on this tick, so the value is taken
      if (same && (cnt_q >= DB_CW'(DEBOUNCE_CNT - 1))) begin
        sw_stable_o <= sync2_q;
      end
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  // The filtered value moves only when the timer has ticked
  a_stable_on_tick: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $changed(sw_stable_o) |-> $past(tick_i));

endmodule

// File: hdl/gpio_regs.sv
/* GPIO register block: output register with byte selects,
   address decode and the registered read-data mux */
`timescale 1ns/1ps

module gpio_regs
  import gpio_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              wr_acc_i,
  input  logic              rd_acc_i,
  input  logic [WB_AW-1:0]  adr_i,
  input  logic [WB_DW-1:0]  dat_i,
  input  logic [WB_SW-1:0]  sel_i,
  input  logic [GPIO_W-1:0] sw_stable_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [WB_DW-1:0]  dat_o
);

  logic              hit_out;
  logic              hit_rb;
  logic [GPIO_W-1:0] gpio_q;
  logic [WB_DW-1:0]  rdata;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  assign hit_out = (adr_i == GPIO_OUT_ADDR);
  assign hit_rb  = (adr_i == GPIO_RB_ADDR);

  // Read mux, zero-extended to the bus width
  always_comb begin
    if (hit_out) begin
      // The base address reads back the debounced switches
      rdata = {{(WB_DW - GPIO_W){1'b0}}, sw_stable_i};
    end else if (hit_rb) begin
      rdata = {{(WB_DW - GPIO_W){1'b0}}, gpio_q};
    end else begin
      // Unmapped addresses still ack, with zero data
      rdata = '0;
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  // Only the two low byte lanes map onto the 16 outputs
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_q <= '0;
    end else if (wr_acc_i && hit_out) begin
      if (sel_i[0]) begin
        gpio_q[7:0] <= dat_i[7:0];
      end
      if (sel_i[1]) begin
        gpio_q[15:8] <= dat_i[15:8];
      end
    end
  end

  // Read data is held until the next accepted read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dat_o <= '0;
    end else if (rd_acc_i) begin
      dat_o <= rdata;
    end
  end

  assign gpio_o = gpio_q;

endmodule

// File: hdl/gpio_wb.sv
/* GPIO peripheral top: bus controller, sampling timer,
   switch debouncer and register block */
`timescale 1ns/1ps

module gpio_wb
  import gpio_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Wishbone slave port
  input  logic [WB_AW-1:0]  adr_i,
  input  logic [WB_DW-1:0]  dat_i,
  input  logic              we_i,
  input  logic [WB_SW-1:0]  sel_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  output logic [WB_DW-1:0]  dat_o,
  output logic              ack_o,
  // Pins
  input  logic [GPIO_W-1:0] sw_i,
  output logic [GPIO_W-1:0] gpio_o
);

  logic              wr_acc;
  logic              rd_acc;
  logic              tick;
  logic [GPIO_W-1:0] sw_stable;
  // Controller state, also watched by the bound checker
  bus_state_t        state_r;

  // ------------------------------------------------------------
  // Bus side
  // ------------------------------------------------------------
  wb_bus_fsm u_bus_fsm (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .we_i     (we_i),
    .wr_acc_o (wr_acc),
    .rd_acc_o (rd_acc),
    .ack_o    (ack_o),
    .state_o  (state_r)
  );

  gpio_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_acc_i    (wr_acc),
    .rd_acc_i    (rd_acc),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .sel_i       (sel_i),
    .sw_stable_i (sw_stable),
    .gpio_o      (gpio_o),
    .dat_o       (dat_o)
  );

  // ------------------------------------------------------------
  // Switch side
  // ------------------------------------------------------------
  sample_timer u_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tick_o  (tick)
  );

  switch_debounce u_debounce (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sw_i        (sw_i),
    .tick_i      (tick),
    .sw_stable_o (sw_stable)
  );

endmodule

// File: hdl/gpio_wb_sva.sv
/* Protocol checker for the GPIO peripheral, with cover points,
   and its bind into the top level */
`timescale 1ns/1ps

module gpio_wb_sva
  import gpio_pkg::*;
(
  input logic              clk_i,
  input logic              rst_n_i,
  input logic [WB_AW-1:0]  adr_i,
  input logic [WB_DW-1:0]  dat_i,
  input logic              we_i,
  input logic [WB_SW-1:0]  sel_i,
  input logic              cyc_i,
  input logic              stb_i,
  input logic [WB_DW-1:0]  dat_o,
  input logic              ack_o,
  input logic [GPIO_W-1:0] sw_i,
  input logic [GPIO_W-1:0] gpio_o,
  input bus_state_t        state_r
);

  logic req;
  logic acc;
  logic wr_base;
  logic [GPIO_W-1:0] gpio_next;

  assign req     = cyc_i & stb_i;
  assign acc     = req & (state_r == IDLE);
  assign wr_base = acc & we_i & (adr_i == GPIO_OUT_ADDR);

  // Expected output after a base write, lane by lane
  assign gpio_next = {sel_i[1] ? dat_i[15:8] : gpio_o[15:8],
                      sel_i[0] ? dat_i[7:0]  : gpio_o[7:0]};

  default clocking cb @(posedge clk_i);
  endclocking

  default disable iff (!rst_n_i);

  // ------------------------------------------------------------
  // Controller protocol
  // ------------------------------------------------------------
  // Reset is synchronous, so the cleared values show one edge later
  a_reset: assert property (disable iff (1'b0) !rst_n_i |=>
    (state_r == IDLE && !ack_o && dat_o == '0 && gpio_o == '0));
  a_idle_hold: assert property ((state_r == IDLE && !req) |=> (state_r == IDLE && !ack_o));
  a_accept: assert property (acc |=> (state_r == ACK && ack_o));
  a_ack_ret: assert property ((state_r == ACK) |=> (state_r == IDLE && !ack_o));
  a_ack_cause: assert property (ack_o |-> $past(acc));
  // Requests held through ACK are served once the controller is back in IDLE
  a_deferred: assert property ((state_r == ACK && req) ##1 req |=> (state_r == ACK));

  // ------------------------------------------------------------
  // Register behaviour
  // ------------------------------------------------------------
  a_gpio_src: assert property ($changed(gpio_o) |-> $past(wr_base));
  a_gpio_val: assert property (wr_base |=> (gpio_o == $past(gpio_next)));
  a_rd_upper: assert property ((acc && !we_i) |=> (dat_o[WB_DW-1:GPIO_W] == '0));
  a_rd_hold: assert property ($changed(dat_o) |-> $past(acc && !we_i));

  // ------------------------------------------------------------
  // Coverage
  // ------------------------------------------------------------
  c_rd_base: cover property ((acc && !we_i && adr_i == GPIO_OUT_ADDR) ##1 ack_o);
  c_rd_rb: cover property ((acc && !we_i && adr_i == GPIO_RB_ADDR) ##1 ack_o);
  c_rd_miss: cover property ((acc && !we_i && adr_i != GPIO_OUT_ADDR &&
                              adr_i != GPIO_RB_ADDR) ##1 ack_o);
  c_wr_base: cover property (wr_base ##1 ack_o);
  c_wr_miss: cover property ((acc && we_i && adr_i != GPIO_OUT_ADDR) ##1 ack_o);
  // Switches seen on a base read once they have settled
  c_sw_read: cover property ((acc && !we_i && adr_i == GPIO_OUT_ADDR && sw_i != '0)
                             ##1 (ack_o && dat_o[GPIO_W-1:0] != '0));
  c_b2b_wr_rd: cover property ((acc && we_i) ##2 (acc && !we_i));
  c_b2b_rd_wr: cover property ((acc && !we_i) ##2 (acc && we_i));
  c_held: cover property (acc ##1 (state_r == ACK && req) ##1 acc);

endmodule

bind gpio_wb gpio_wb_sva u_gpio_wb_sva (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .adr_i   (adr_i),
  .dat_i   (dat_i),
  .we_i    (we_i),
  .sel_i   (sel_i),
  .cyc_i   (cyc_i),
  .stb_i   (stb_i),
  .dat_o   (dat_o),
  .ack_o   (ack_o),
  .sw_i    (sw_i),
  .gpio_o  (gpio_o),
  .state_r (state_r)
);

// File: tests/tb_clk_gen.sv
/* Testbench clock and reset source: 4 ns clock,
   active-low reset held for the first 5 rising edges */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, 2 ns high and 2 ns low
  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

  // Reset is synchronous in the DUT, so it is released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: tests/tb_gpio_wb.sv
/* GPIO peripheral testbench: random bus traffic and switch stimulus,
   reference model of the registers, checks and watchdog */
`timescale 1ns/1ps

module tb_gpio_wb
  import gpio_pkg::*;
();

  localparam int CLK_NS    = 4;
  localparam int N_WR      = 40;
  localparam int N_RD      = 30;
  localparam int N_SW      = 12;
  localparam int N_B2B     = 8;
  localparam int B2B_LEN   = 4;
  localparam int N_TXN     = N_WR + N_RD + N_SW + N_B2B * B2B_LEN;
  // Cycles for a switch change to cross the synchroniser and the filter
  localparam int SETTLE    = (DEBOUNCE_CNT + 2) * TICK_DIV + 2;
  localparam int WORST_CYC = 2 + SETTLE;
  localparam int ACK_LIMIT = 8;

  logic              clk;
  logic              rst_n;
  logic [WB_AW-1:0]  adr;
  logic [WB_DW-1:0]  dat_w;
  logic              we;
  logic [WB_SW-1:0]  sel;
  logic              cyc;
  logic              stb;
  logic [WB_DW-1:0]  dat_r;
  logic              ack;
  logic [GPIO_W-1:0] sw;
  logic [GPIO_W-1:0] gpio;

  // Reference model state
  logic [GPIO_W-1:0] exp_gpio = '0;
  logic [GPIO_W-1:0] exp_sw   = '0;
  logic [WB_DW-1:0]  last_rd  = '0;
  int                err_cnt  = 0;
  int                chk_cnt  = 0;
  int                req_cnt  = 0;
  int                ack_cnt  = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gpio_wb uut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .adr_i   (adr),
    .dat_i   (dat_w),
    .we_i    (we),
    .sel_i   (sel),
    .cyc_i   (cyc),
    .stb_i   (stb),
    .dat_o   (dat_r),
    .ack_o   (ack),
    .sw_i    (sw),
    .gpio_o  (gpio)
  );

  // Every ack pulse is counted, so a missing or extra one shows at the end
  always @(negedge clk) begin
    if (rst_n && ack) begin
      ack_cnt++;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [WB_DW-1:0] got,
                             input logic [WB_DW-1:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h at %0t ns", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  // Word address that hits neither mapped register
  function automatic logic [WB_AW-1:0] other_addr();
    logic [WB_AW-1:0] a;
    a = WB_AW'($urandom) & 32'h0000_0FFC;
    if (a == GPIO_OUT_ADDR || a == GPIO_RB_ADDR) begin
      a = a + 32'h8;
    end
    return a;
  endfunction

  // Expected read data, taken from the register map
  function automatic logic [WB_DW-1:0] expect_read(input logic [WB_AW-1:0] a);
    if (a == GPIO_RB_ADDR) begin
      return {{(WB_DW - GPIO_W){1'b0}}, exp_gpio};
    end else if (a == GPIO_OUT_ADDR) begin
      return {{(WB_DW - GPIO_W){1'b0}}, exp_sw};
    end
    return '0;
  endfunction

  // One single-beat transfer; with hold set, cyc and stb stay high for the next beat
  task automatic bus_xfer(input logic wr, input logic [WB_AW-1:0] a,
                          input logic [WB_DW-1:0] d, input logic [WB_SW-1:0] s,
                          input logic hold, output logic [WB_DW-1:0] rdata,
                          output logic [GPIO_W-1:0] gpio_seen);
    int waited;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    sel   <= s;
    req_cnt++;
    // Accepted on the next edge, so ack is seen on the second falling edge
    @(negedge clk);
    waited = 1;
    while (!ack && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    chk_cnt++;
    assert (ack && waited == 2) else begin
      err_cnt++;
      if (!ack) begin
        $display("No ack_o within %0d cycles of a request at %0t ns", ACK_LIMIT, $time);
      end else begin
        $display("ERR ack_o latency got %h expected %h at %0t ns", waited, 2, $time);
      end
    end
    rdata     = dat_r;
    gpio_seen = gpio;
    if (!hold) begin
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
    end
  endtask

  task automatic do_write(input logic [WB_AW-1:0] a, input logic hold);
    logic [WB_DW-1:0]  d;
    logic [WB_SW-1:0]  s;
    logic [WB_DW-1:0]  rdata;
    logic [GPIO_W-1:0] gpio_seen;
    d = $urandom;
    s = WB_SW'($urandom_range(0, 15));
    bus_xfer(1'b1, a, d, s, hold, rdata, gpio_seen);
    // Only byte lanes 0 and 1 of the base address are writable
    if (a == GPIO_OUT_ADDR) begin
      if (s[0]) begin
        exp_gpio[7:0] = d[7:0];
      end
      if (s[1]) begin
        exp_gpio[15:8] = d[15:8];
      end
    end
    check_value("gpio_o", gpio_seen, exp_gpio);
    // A write must not disturb the held read data
    check_value("dat_o", rdata, last_rd);
  endtask

  task automatic do_read(input logic [WB_AW-1:0] a, input logic hold,
                         output logic [WB_DW-1:0] rdata);
    logic [WB_DW-1:0]  exp;
    logic [GPIO_W-1:0] gpio_seen;
    exp = expect_read(a);
    bus_xfer(1'b0, a, $urandom, WB_SW'($urandom_range(0, 15)), hold, rdata, gpio_seen);
    check_value("dat_o", rdata, exp);
    check_value("gpio_o", gpio_seen, exp_gpio);
    last_rd = exp;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [WB_DW-1:0]  rdata;
    logic [GPIO_W-1:0] sw_val;
    logic              hold;
    void'($urandom(32'hd30c));
    cyc   <= 1'b0;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= '0;
    dat_w <= '0;
    sel   <= '0;
    sw    <= '0;

    // Outputs come out of reset cleared
    @(posedge clk);
    while (!rst_n) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_value("ack_o", ack, '0);
    check_value("dat_o", dat_r, '0);
    check_value("gpio_o", gpio, '0);

    // Random writes, mostly to the base address
    for (int i = 0; i < N_WR; i++) begin
      case ($urandom_range(0, 3))
        0, 1:    do_write(GPIO_OUT_ADDR, 1'b0);
        2:       do_write(GPIO_RB_ADDR, 1'b0);
        default: do_write(other_addr(), 1'b0);
      endcase
    end

    // Reads of both registers and of unmapped space
    for (int i = 0; i < N_RD; i++) begin
      case ($urandom_range(0, 2))
        0:       do_read(GPIO_RB_ADDR, 1'b0, rdata);
        1:       do_read(GPIO_OUT_ADDR, 1'b0, rdata);
        default: do_read(other_addr(), 1'b0, rdata);
      endcase
    end

    // New switch values held until the debouncer has taken them
    for (int i = 0; i < N_SW; i++) begin
      sw_val = GPIO_W'($urandom);
      @(posedge clk);
      sw <= sw_val;
      repeat (SETTLE) @(posedge clk);
      exp_sw = sw_val;
      do_read(GPIO_OUT_ADDR, 1'b0, rdata);
      check_value("dat_o[31:16]", rdata[WB_DW-1:GPIO_W], '0);
    end

    // Back-to-back beats with stb held high through each ack
    for (int g = 0; g < N_B2B; g++) begin
      for (int b = 0; b < B2B_LEN; b++) begin
        hold = (b != B2B_LEN - 1);
        case ($urandom_range(0, 3))
          0:       do_write(GPIO_OUT_ADDR, hold);
          1:       do_read(GPIO_RB_ADDR, hold, rdata);
          2:       do_read(GPIO_OUT_ADDR, hold, rdata);
          default: do_read(other_addr(), hold, rdata);
        endcase
      end
    end

    repeat (4) @(negedge clk);
    check_value("ack_o count", ack_cnt, req_cnt);

    $display("Checks %0d, errors %0d, requests %0d, acks %0d",
             chk_cnt, err_cnt, req_cnt, ack_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized for every transfer taking the worst case, twice over
  initial begin
    #(N_TXN * WORST_CYC * CLK_NS * 2 + 20 * CLK_NS);
    $display("Watchdog expired before the test sequence completed");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: compile.f
hdl/gpio_pkg.sv
hdl/wb_bus_fsm.sv
hdl/sample_timer.sv
hdl/switch_debounce.sv
hdl/gpio_regs.sv
hdl/gpio_wb.sv
hdl/gpio_wb_sva.sv
tests/tb_clk_gen.sv
tests/tb_gpio_wb.sv
